// File: filelist.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/fetch_pkg.sv
rtl/btb.sv
rtl/ras.sv
rtl/next_pc_sel.sv
rtl/fetch_stage_bram.sv
rtl/imem_bram.sv
rtl/fetch_unit.sv
sim/clk_gen.sv
sim/fetch_unit_tb.sv

// File: rtl/btb.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module btb (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic [`FETCH_XLEN-1:0] pc,
  input  wire fetch_pkg::btb_update_t wr,
  output logic                        hit,
  output logic [`FETCH_XLEN-1:0]      target,
  output logic                        is_return
);

  localparam int IDX_W = $clog2(`BTB_ENTRIES);
  localparam int TAG_W = `FETCH_XLEN - IDX_W - 2;

  logic [`BTB_ENTRIES-1:0] valid_q;
  logic [`BTB_ENTRIES-1:0] ret_q;
  logic [TAG_W-1:0]        tag_q    [`BTB_ENTRIES];
  logic [`FETCH_XLEN-1:0]  target_q [`BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [TAG_W-1:0] wr_tag;

  // Bits 1:0 are always zero for RV32I without compressed instructions
  assign rd_idx = pc[IDX_W+1:2];
  assign rd_tag = pc[`FETCH_XLEN-1:IDX_W+2];
  assign wr_idx = wr.pc[IDX_W+1:2];
  assign wr_tag = wr.pc[`FETCH_XLEN-1:IDX_W+2];

  // Lookup is purely combinational so the target can steer pc_next this cycle
  // Every hit counts as taken, the table only holds taken branches and jumps
  assign hit       = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign target    = target_q[rd_idx];
  assign is_return = hit && ret_q[rd_idx];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (wr.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // A training write simply replaces whatever entry sat at that index
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= wr.target;
      ret_q[wr_idx]    <= wr.is_return;
    end
  end

endmodule

`default_nettype wire

// File: rtl/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Width of every fetch address and of the PC register
`define FETCH_XLEN 32

// BTB size, indexed with the PC bits just above bit 1
`define BTB_ENTRIES 16

// Return address stack depth, a power of two so the pointer wraps on its own
`define RAS_DEPTH 4

// Instruction memory depth in 32-bit words
`define IMEM_WORDS 256

// First address fetched after reset
`define RESET_PC 32'h0000_0000

`endif

// File: rtl/fetch_pkg.sv
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  // Prediction that chose a fetch address, carried along with that address
  typedef struct packed {
    logic                   btb_hit;
    logic                   taken;
    logic                   is_return;
    logic                   ras_used;
    logic [`FETCH_XLEN-1:0] target;
  } pred_t;

  // One fetched instruction handed to decode
  typedef struct packed {
    logic                   valid;
    logic [31:0]            instr;
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] pc_plus4;
    pred_t                  pred;
  } fetch_out_t;

  // Control flow correction coming back from execute
  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] target;
  } redirect_t;

  // BTB training write
  typedef struct packed {
    logic                   valid;
    logic [`FETCH_XLEN-1:0] pc;
    logic [`FETCH_XLEN-1:0] target;
    logic                   is_return;
  } btb_update_t;

  // Instruction memory load, addressed by word
  typedef struct packed {
    logic                           en;
    logic [$clog2(`IMEM_WORDS)-1:0] addr;
    logic [31:0]                    data;
  } imem_wr_t;

endpackage

`default_nettype wire

// File: rtl/fetch_stage_bram.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_stage_bram (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   valid_if,
  input  wire logic [`FETCH_XLEN-1:0] pc_next,
  input  wire fetch_pkg::pred_t       pred,
  input  wire logic                   flush,
  input  wire logic                   advance,
  output logic                        imem_ren,
  output logic [`FETCH_XLEN-1:0]      imem_raddr,
  input  wire logic [31:0]            imem_rdata,
  output fetch_pkg::fetch_out_t       fetch
);

  logic [`FETCH_XLEN-1:0] pc_q;
  logic [`FETCH_XLEN-1:0] pc_plus4_q;
  logic [`FETCH_XLEN-1:0] target_q;
  logic                   valid_q;
  logic                   btb_hit_q;
  logic                   taken_q;
  logic                   is_return_q;
  logic                   ras_used_q;

  // Early fetch: the RAM is addressed with pc_next, so a predicted target is
  // read in the same cycle the prediction is made
  // A flushed cycle issues no read, next_pc_sel presents the target again
  assign imem_raddr = pc_next;
  assign imem_ren   = valid_if && advance && !flush;

  // The RAM output register holds the word read on the last advancing edge
  // These registers capture the matching address and prediction on that edge
  always_ff @(posedge clk) begin
    if (advance) begin
      pc_q       <= pc_next;
      pc_plus4_q <= pc_next + `FETCH_XLEN'(4);
      target_q   <= pred.target;
    end
  end

  // valid_q follows the read enable, which keeps it low until the first real
  // read and drops it for the cycle after a flush
  // A dead bundle carries no prediction either
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      btb_hit_q   <= 1'b0;
      taken_q     <= 1'b0;
      is_return_q <= 1'b0;
      ras_used_q  <= 1'b0;
    end else if (advance) begin
      valid_q     <= valid_if && !flush;
      btb_hit_q   <= pred.btb_hit && !flush;
      taken_q     <= pred.taken && !flush;
      is_return_q <= pred.is_return && !flush;
      ras_used_q  <= pred.ras_used && !flush;
    end
  end

  // While stalled there is no read, so the RAM output and these registers
  // all hold and the bundle stays steady
  always_comb begin
    fetch.valid          = valid_q;
    // The RAM output is meaningless for a dead bundle, decode sees a NOP there
    fetch.instr          = valid_q ? imem_rdata : isa_pkg::I_NOP;
    fetch.pc             = pc_q;
    fetch.pc_plus4       = pc_plus4_q;
    fetch.pred.btb_hit   = btb_hit_q;
    fetch.pred.taken     = taken_q;
    fetch.pred.is_return = is_return_q;
    fetch.pred.ras_used  = ras_used_q;
    fetch.pred.target    = target_q;
  end

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_unit (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   stall,
  input  wire fetch_pkg::redirect_t   redirect,
  input  wire fetch_pkg::btb_update_t btb_wr,
  input  wire fetch_pkg::imem_wr_t    imem_wr,
  output fetch_pkg::fetch_out_t       fetch
);

  logic                   advance;
  logic [`FETCH_XLEN-1:0] pc;
  logic [`FETCH_XLEN-1:0] pc_next;
  fetch_pkg::pred_t       pred;
  logic                   ras_pop;
  logic                   valid_if;
  logic                   btb_hit;
  logic [`FETCH_XLEN-1:0] btb_target;
  logic                   btb_is_return;
  logic                   ras_valid;
  logic [`FETCH_XLEN-1:0] ras_top;
  logic                   imem_ren;
  logic [`FETCH_XLEN-1:0] imem_raddr;
  logic [31:0]            imem_rdata;

  // Decode back-pressure freezes the whole front end
  assign advance = !stall;

  // The BTB looks up the address read last cycle
  btb i_btb (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc        (pc),
    .wr        (btb_wr),
    .hit       (btb_hit),
    .target    (btb_target),
    .is_return (btb_is_return)
  );

  // Calls are pushed as they leave fetch, pops come from the selector
  ras i_ras (
    .clk       (clk),
    .rst_n     (rst_n),
    .fetch     (fetch),
    .advance   (advance),
    .pop       (ras_pop),
    .top_valid (ras_valid),
    .top       (ras_top)
  );

  next_pc_sel i_next_pc_sel (
    .clk           (clk),
    .rst_n         (rst_n),
    .advance       (advance),
    .redirect      (redirect),
    .btb_hit       (btb_hit),
    .btb_target    (btb_target),
    .btb_is_return (btb_is_return),
    .ras_valid     (ras_valid),
    .ras_top       (ras_top),
    .pc            (pc),
    .pc_next       (pc_next),
    .pred          (pred),
    .ras_pop       (ras_pop),
    .valid_if      (valid_if)
  );

  // A redirect doubles as the flush of the stage
  fetch_stage_bram i_fetch_stage_bram (
    .clk        (clk),
    .rst_n      (rst_n),
    .valid_if   (valid_if),
    .pc_next    (pc_next),
    .pred       (pred),
    .flush      (redirect.valid),
    .advance    (advance),
    .imem_ren   (imem_ren),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .fetch      (fetch)
  );

  imem_bram i_imem_bram (
    .clk   (clk),
    .ren   (imem_ren),
    .raddr (imem_raddr),
    .rdata (imem_rdata),
    .wr    (imem_wr)
  );

endmodule

`default_nettype wire

// File: rtl/imem_bram.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module imem_bram (
  input  wire logic                   clk,
  input  wire logic                   ren,
  input  wire logic [`FETCH_XLEN-1:0] raddr,
  output logic [31:0]                 rdata,
  input  wire fetch_pkg::imem_wr_t    wr
);

  localparam int AW = $clog2(`IMEM_WORDS);

  logic [31:0] mem [`IMEM_WORDS];

  // Byte address in, word index out; the upper bits alias the array
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
    // rdata keeps its value whenever ren is low
    if (ren) begin
      rdata <= mem[raddr[AW+1:2]];
    end
  end

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // J-type layout, which is how JAL is laid out
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // I-type layout, shared by JALR and the ALU immediate group
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // One instruction word seen through either layout
  typedef union packed {
    j_type_t j;
    i_type_t i;
  } instr_u;

  localparam logic [6:0] OP_IMM  = 7'b0010011;
  localparam logic [6:0] OP_JAL  = 7'b1101111;
  localparam logic [6:0] OP_JALR = 7'b1100111;

  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;

  // addi x0, x0, 0
  localparam logic [31:0] I_NOP = {12'd0, REG_ZERO, 3'b000, REG_ZERO, OP_IMM};

endpackage

`default_nettype wire

// File: rtl/next_pc_sel.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module next_pc_sel (
  input  wire logic                   clk,
  input  wire logic                   rst_n,
  input  wire logic                   advance,
  input  wire fetch_pkg::redirect_t   redirect,
  input  wire logic                   btb_hit,
  input  wire logic [`FETCH_XLEN-1:0] btb_target,
  input  wire logic                   btb_is_return,
  input  wire logic                   ras_valid,
  input  wire logic [`FETCH_XLEN-1:0] ras_top,
  output logic [`FETCH_XLEN-1:0]      pc,
  output logic [`FETCH_XLEN-1:0]      pc_next,
  output fetch_pkg::pred_t            pred,
  output logic                        ras_pop,
  output logic                        valid_if
);

  logic [`FETCH_XLEN-1:0] pc_q;
  logic                   valid_q;
  logic                   fetched_q;
  logic                   use_btb;
  logic                   use_ras;

  // pc_q is the address presented last cycle; fetched_q says whether it was
  // actually read, which is false right after reset and right after a redirect
  // Predictions are only trusted for an address that really went to memory
  assign use_btb = fetched_q && btb_hit;
  assign use_ras = use_btb && btb_is_return && ras_valid;

  always_comb begin
    pred = '0;
    if (redirect.valid) begin
      pc_next = redirect.target;
    end else if (!fetched_q) begin
      // Present the reset PC or the redirect target again until it is read
      pc_next = pc_q;
    end else if (use_ras) begin
      // Return predicted by the BTB, but the stack knows the real caller
      pc_next        = ras_top;
      pred.btb_hit   = 1'b1;
      pred.taken     = 1'b1;
      pred.is_return = 1'b1;
      pred.ras_used  = 1'b1;
    end else if (use_btb) begin
      pc_next        = btb_target;
      pred.btb_hit   = 1'b1;
      pred.taken     = 1'b1;
      pred.is_return = btb_is_return;
    end else begin
      pc_next = pc_q + `FETCH_XLEN'(4);
    end
    pred.target = pc_next;
  end

  // Nothing moves without advance, so a redirect must be held until it is taken
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q      <= `RESET_PC;
      valid_q   <= 1'b0;
      fetched_q <= 1'b0;
    end else if (advance) begin
      pc_q      <= pc_next;
      valid_q   <= 1'b1;
      fetched_q <= valid_q && !redirect.valid;
    end
  end

  // Pop exactly when the RAS target is the address being read this edge
  assign ras_pop  = advance && !redirect.valid && use_ras;
  assign pc       = pc_q;
  assign valid_if = valid_q;

endmodule

`default_nettype wire

// File: rtl/ras.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module ras (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire fetch_pkg::fetch_out_t fetch,
  input  wire logic                  advance,
  input  wire logic                  pop,
  output logic                       top_valid,
  output logic [`FETCH_XLEN-1:0]     top
);

  localparam int PTR_W = $clog2(`RAS_DEPTH);
  localparam int CNT_W = $clog2(`RAS_DEPTH + 1);

  logic [`FETCH_XLEN-1:0] stack_q [`RAS_DEPTH];
  logic [PTR_W-1:0]       ptr_q;
  logic [CNT_W-1:0]       count_q;

  isa_pkg::instr_u word;
  logic            is_jal_call;
  logic            is_jalr_call;
  logic            push;
  logic            pop_ok;

  // Predecode the bundle leaving fetch
  // A call is any jump that links into ra, direct or indirect
  assign word         = fetch.instr;
  assign is_jal_call  = (word.j.opcode == isa_pkg::OP_JAL) && (word.j.rd == isa_pkg::REG_RA);
  assign is_jalr_call = (word.i.opcode == isa_pkg::OP_JALR) && (word.i.rd == isa_pkg::REG_RA);

  // Only push once, on the edge where decode takes the bundle
  assign push = fetch.valid && advance && (is_jal_call || is_jalr_call);

  // Popping an empty stack does nothing
  assign pop_ok = pop && (count_q != '0);

  // ptr_q always points at the current top entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q   <= '0;
      count_q <= '0;
    end else begin
      unique case ({push, pop_ok})
        2'b10: begin
          ptr_q <= ptr_q + PTR_W'(1);
          // Once full, the oldest entry is overwritten and the count saturates
          if (count_q != CNT_W'(`RAS_DEPTH)) begin
            count_q <= count_q + CNT_W'(1);
          end
        end
        2'b01: begin
          ptr_q   <= ptr_q - PTR_W'(1);
          count_q <= count_q - CNT_W'(1);
        end
        // Push plus pop is a replacement of the top, depth is unchanged
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      if (pop_ok) begin
        stack_q[ptr_q] <= fetch.pc_plus4;
      end else begin
        stack_q[ptr_q + PTR_W'(1)] <= fetch.pc_plus4;
      end
    end
  end

  assign top_valid = (count_q != '0);
  assign top       = stack_q[ptr_q];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the fetch unit testbench; the pass line decides the result
verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
  --top-module fetch_unit_tb -o fetch_unit_sim || exit 1
sim_out=$(./obj_dir/fetch_unit_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "TESTBENCH PASSED" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: sim/clk_gen.sv
`default_nettype none
`timescale 1ns/1ps

module clk_gen #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst_n
);

  // Free running clock, the period is twice HALF_PERIOD
  initial begin
    clk = 1'b0;
    forever begin
      #(HALF_PERIOD) clk = ~clk;
    end
  end

  // Reset is let go on a falling edge, well away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/fetch_unit_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_params.svh"

module fetch_unit_tb;

  localparam int PERIOD_NS    = 8;
  localparam int RESET_CYCLES = 8;
  localparam int AW           = $clog2(`IMEM_WORDS);
  localparam int WIDE         = 160;
  localparam int NUM_BTB      = 3;
  localparam int NUM_ROWS     = 24;
  localparam int MAX_STALL    = 3;
  // Setup covers reset, the memory load and the BTB training
  localparam int SETUP_CYCLES = RESET_CYCLES + `IMEM_WORDS + NUM_BTB + 4;
  localparam int TIMEOUT_NS   = (NUM_ROWS * (MAX_STALL + 4) + SETUP_CYCLES) * PERIOD_NS;
  // Canonical RV32I NOP is addi x0, x0, 0
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  // One row of stimulus with exp_flags ordered as {btb_hit, taken, is_return, ras_used}
  typedef struct packed {
    logic        rand_stall;
    logic [1:0]  stall_cycles;
    logic        redirect_en;
    logic [31:0] redirect_target;
    logic [31:0] exp_pc;
    logic [3:0]  exp_flags;
  } row_t;

  logic                   clk;
  logic                   rst_n;
  logic                   stall;
  fetch_pkg::redirect_t   redirect;
  fetch_pkg::btb_update_t btb_wr;
  fetch_pkg::imem_wr_t    imem_wr;
  fetch_pkg::fetch_out_t  fetch;

  logic [31:0]            image [`IMEM_WORDS];
  fetch_pkg::btb_update_t btb_table [NUM_BTB];
  row_t                   rows [NUM_ROWS];
  // Reference model state holds the return stack, the next expected pc and its flags
  logic [31:0]            ras_model [$];
  logic [31:0]            model_pc;
  logic [3:0]             model_flags;
  logic [31:0]            lfsr;
  int                     error_count;

  clk_gen #(
    .HALF_PERIOD  (PERIOD_NS / 2),
    .RESET_CYCLES (RESET_CYCLES)
  ) i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  fetch_unit i_fetch_unit (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .redirect (redirect),
    .btb_wr   (btb_wr),
    .imem_wr  (imem_wr),
    .fetch    (fetch)
  );

  // addi x5, x0, idx so every word of the image is different
  function automatic logic [31:0] filler_word(input int idx);
    logic [11:0] imm;
    imm = 12'(idx);
    return {imm, isa_pkg::REG_ZERO, 3'b000, 5'd5, isa_pkg::OP_IMM};
  endfunction

  // Taps 32, 22, 2 and 1 with the new bit entering at bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check_value(input string name, input logic [WIDE-1:0] got,
                             input logic [WIDE-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("Error: time %0t, %s is %0h, expected %0h", $time, name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Two LFSR steps give a stall count from 0 to 3
  task automatic draw_stall(output int n);
    logic [1:0] bits;
    lfsr    = lfsr_next(lfsr);
    bits[1] = lfsr[0];
    lfsr    = lfsr_next(lfsr);
    bits[0] = lfsr[0];
    n       = int'(bits);
  endtask

  // Works out the next expected pc once the bundle at pc is accepted
  task automatic predict_next(input logic [31:0] pc, input logic [31:0] instr,
                              input row_t row);
    logic        hit;
    logic        ret;
    logic        call;
    logic [31:0] tgt;
    hit = 1'b0;
    ret = 1'b0;
    tgt = '0;
    foreach (btb_table[i]) begin
      if (btb_table[i].pc == pc) begin
        hit = 1'b1;
        ret = btb_table[i].is_return;
        tgt = btb_table[i].target;
      end
    end
    // A call is JAL or JALR that links into ra
    call = (instr[11:7] == isa_pkg::REG_RA) &&
           ((instr[6:0] == isa_pkg::OP_JAL) || (instr[6:0] == isa_pkg::OP_JALR));
    if (row.redirect_en) begin
      model_pc    = row.redirect_target;
      model_flags = 4'b0000;
    end else if (hit && ret && (ras_model.size() > 0)) begin
      model_pc    = ras_model.pop_back();
      model_flags = 4'b1111;
    end else if (hit) begin
      model_pc    = tgt;
      model_flags = {2'b11, ret, 1'b0};
    end else begin
      model_pc    = pc + 32'd4;
      model_flags = 4'b0000;
    end
    // The stack wraps, so a full stack loses its oldest entry
    if (call) begin
      if (ras_model.size() == `RAS_DEPTH) begin
        void'(ras_model.pop_front());
      end
      ras_model.push_back(pc + 32'd4);
    end
  endtask

  // Waits for a valid bundle, stalls it, then lets it be accepted on the next rising edge
  task automatic apply_row(input row_t row);
    int                    n;
    logic [31:0]           pc;
    logic [31:0]           instr;
    fetch_pkg::fetch_out_t held;
    if (row.rand_stall) begin
      draw_stall(n);
    end else begin
      n = int'(row.stall_cycles);
    end
    @(negedge clk);
    stall    = 1'b0;
    redirect = '0;
    // Empty slots after reset or a flush pass by without being accepted
    // An empty slot shows a NOP and no prediction
    while (!fetch.valid) begin
      check_value("fetch.instr", WIDE'(fetch.instr), WIDE'(NOP_WORD));
      check_value("fetch.pred flags", WIDE'({fetch.pred.btb_hit, fetch.pred.taken,
                  fetch.pred.is_return, fetch.pred.ras_used}), WIDE'(4'b0000));
      @(negedge clk);
    end
    held = fetch;
    for (int s = 0; s < n; s++) begin
      stall = 1'b1;
      @(negedge clk);
      check_value("fetch while stalled", WIDE'(fetch), WIDE'(held));
    end
    stall = 1'b0;
    if (row.redirect_en) begin
      redirect.valid  = 1'b1;
      redirect.target = row.redirect_target;
    end
    pc    = model_pc;
    instr = image[pc[AW+1:2]];
    // The model must have reached the pc and flags the table intends
    check_value("model pc vs table", WIDE'(pc), WIDE'(row.exp_pc));
    check_value("model flags vs table", WIDE'(model_flags), WIDE'(row.exp_flags));
    check_value("fetch.pc", WIDE'(fetch.pc), WIDE'(pc));
    check_value("fetch.pc_plus4", WIDE'(fetch.pc_plus4), WIDE'(pc + 32'd4));
    check_value("fetch.instr", WIDE'(fetch.instr), WIDE'(instr));
    check_value("fetch.pred flags", WIDE'({fetch.pred.btb_hit, fetch.pred.taken,
                fetch.pred.is_return, fetch.pred.ras_used}), WIDE'(model_flags));
    check_value("fetch.pred.target", WIDE'(fetch.pred.target), WIDE'(pc));
    predict_next(pc, instr, row);
  endtask

  initial begin
    stall       = 1'b1;
    redirect    = '0;
    btb_wr      = '0;
    imem_wr     = '0;
    lfsr        = 32'h82f11370;
    error_count = 0;
    model_pc    = `RESET_PC;
    model_flags = 4'b0000;
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      image[i] = filler_word(i);
    end
    // jal ra, +0x20 at 0x20 and jalr x0, 0(ra) at 0x44
    image[8]  = {1'b0, 10'h010, 1'b0, 8'h00, isa_pkg::REG_RA, isa_pkg::OP_JAL};
    image[17] = {12'd0, isa_pkg::REG_RA, 3'b000, isa_pkg::REG_ZERO, isa_pkg::OP_JALR};
    // The return entry points at the wrong target 0xc0 so only the stack knows the caller
    btb_table = '{
      {1'b1, 32'h10, 32'h30, 1'b0},
      {1'b1, 32'h20, 32'h40, 1'b0},
      {1'b1, 32'h44, 32'hc0, 1'b1}
    };
    // The last rows revisit the return with an empty stack so the BTB target wins
    rows = '{
      {1'b0, 2'd0, 1'b0, 32'h00, 32'h00, 4'b0000},
      {1'b0, 2'd1, 1'b0, 32'h00, 32'h04, 4'b0000},
      {1'b0, 2'd0, 1'b0, 32'h00, 32'h08, 4'b0000},
      {1'b0, 2'd2, 1'b0, 32'h00, 32'h0c, 4'b0000},
      {1'b0, 2'd0, 1'b0, 32'h00, 32'h10, 4'b0000},
      {1'b0, 2'd0, 1'b0, 32'h00, 32'h30, 4'b1100},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h34, 4'b0000},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h38, 4'b0000},
      {1'b1, 2'd0, 1'b1, 32'h80, 32'h3c, 4'b0000},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h80, 4'b0000},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h84, 4'b0000},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h88, 4'b0000},
      {1'b0, 2'd1, 1'b1, 32'h18, 32'h8c, 4'b0000},
      {1'b0, 2'd0, 1'b0, 32'h00, 32'h18, 4'b0000},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h1c, 4'b0000},
      {1'b0, 2'd2, 1'b0, 32'h00, 32'h20, 4'b0000},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h40, 4'b1100},
      {1'b0, 2'd1, 1'b0, 32'h00, 32'h44, 4'b0000},
      {1'b0, 2'd0, 1'b0, 32'h00, 32'h24, 4'b1111},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h28, 4'b0000},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'h2c, 4'b0000},
      {1'b0, 2'd3, 1'b1, 32'h44, 32'h30, 4'b0000},
      {1'b0, 2'd0, 1'b0, 32'h00, 32'h44, 4'b0000},
      {1'b1, 2'd0, 1'b0, 32'h00, 32'hc0, 4'b1110}
    };
    // The load starts in reset and runs on past it with the front end stalled
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      @(negedge clk);
      imem_wr.en   = 1'b1;
      imem_wr.addr = AW'(i);
      imem_wr.data = image[i];
    end
    @(negedge clk);
    imem_wr = '0;
    wait (rst_n === 1'b1);
    // BTB valid bits clear in reset, so training comes after it
    for (int i = 0; i < NUM_BTB; i++) begin
      btb_wr = btb_table[i];
      @(negedge clk);
    end
    btb_wr = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(rows[r]);
    end
    @(negedge clk);
    redirect = '0;
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "%0d checks failed", error_count);
    end
  end

  // Ends a run that stops making progress
  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before all rows were accepted", TIMEOUT_NS);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog timeout");
  end

endmodule

`default_nettype wire
